//--- hdl/eth_dma_pkg.sv
//================================================
// shared constants for the ethernet mac tx dma path
// all blocks run on one clock, ahb_hclk
// word counter covers byte lengths up to 4092
// fifo depth must stay a power of two
//================================================

`default_nettype none

package eth_dma_pkg;

	// bus and descriptor widths
	localparam int DATA_W = 32;
	localparam int LEN_W = 12;
	localparam int WCNT_W = 10;

	// tx data buffer sizing
	localparam int FIFO_DEPTH = 8;
	localparam int CNT_W = 4;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	//================================================
	// ahb-lite encodings
	//================================================
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [2:0] HSIZE_WORD = 3'b010;
	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	// privileged, data access
	localparam logic [3:0] HPROT_DATA = 4'b0011;
	localparam logic [1:0] HRESP_OKAY = 2'b00;
	localparam logic [1:0] HRESP_ERROR = 2'b01;

	//================================================
	// datalink fsm
	//================================================
	// one-hot, bit 1 and bit 4 were arbitration and rx data
	typedef enum logic [5:0]
	{
		DL_IDLE = 6'b000001,
		DL_DESCRIPTOR = 6'b000100,
		DL_TX_DATA = 6'b001000,
		DL_END = 6'b100000
	} dl_state_t;

endpackage

`default_nettype wire

//--- hdl/eth_datalink_ctrl.sv
//================================================
// datalink control for the tx path
// txdb_enable is a level, held high it restarts
// the process after every end state
// byte length rounds up to whole words
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_datalink_ctrl
(
	input  logic                            ahb_hclk,
	input  logic                            ahb_hrstn,
	input  logic                            txdb_enable,
	input  logic [eth_dma_pkg::DATA_W-1:0]  r_tdes0,
	input  logic [eth_dma_pkg::DATA_W-1:0]  r_tdes3,
	input  logic                            done,
	input  logic                            hresp_err,
	input  logic                            last_taken,
	output logic                            start,
	output logic [eth_dma_pkg::DATA_W-1:0]  base_addr,
	output logic [eth_dma_pkg::WCNT_W-1:0]  word_cnt,
	output logic                            fifo_flush,
	output logic                            process_doing
);

	import eth_dma_pkg::*;

	dl_state_t          state;
	dl_state_t          state_nxt;
	// tx process request from the register enable
	logic               req_q;
	// every word of the buffer has been read over ahb
	logic               rd_done;
	logic [LEN_W:0]     len_up;

	// length plus three, bits above 1 give the word count
	assign len_up = {1'b0, r_tdes3[LEN_W-1:0]} + (LEN_W+1)'(3);

	//================================================
	// request register
	//================================================
	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
			req_q <= 1'b0;
		else if (state == DL_END)
			req_q <= 1'b0;
		else if (state == DL_IDLE && txdb_enable)
			req_q <= 1'b1;
	end

	//================================================
	// datalink fsm
	//================================================
	always_comb
	begin
		state_nxt = state;
		case (state)
			DL_IDLE:
				if (req_q)
					state_nxt = DL_DESCRIPTOR;
			// descriptor latch takes one cycle
			DL_DESCRIPTOR:
				state_nxt = DL_TX_DATA;
			DL_TX_DATA:
				if (hresp_err || (last_taken && rd_done))
					state_nxt = DL_END;
			DL_END:
				state_nxt = DL_IDLE;
			default:
				state_nxt = DL_IDLE;
		endcase
	end

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			state <= DL_IDLE;
			start <= 1'b0;
			fifo_flush <= 1'b0;
			rd_done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// high in the first tx-data cycle
			start <= state == DL_DESCRIPTOR;
			// drop words of an aborted buffer
			fifo_flush <= state == DL_TX_DATA && hresp_err;
			if (start)
				rd_done <= 1'b0;
			else if (done)
				rd_done <= 1'b1;
		end
	end

	// descriptor fields, valid from the first tx-data cycle
	always_ff @(posedge ahb_hclk)
	begin
		if (state == DL_DESCRIPTOR)
		begin
			base_addr <= r_tdes0;
			word_cnt <= len_up[WCNT_W+1:2];
		end
	end

	assign process_doing = state == DL_TX_DATA;

endmodule

`default_nettype wire

//--- hdl/eth_dma_ahb_reader.sv
//================================================
// ahb-lite read master, single nonseq word reads
// at most two transfers in flight, address and data phase
// fifo must be empty when start pulses
// an error response cancels the queued address phase
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_dma_ahb_reader
(
	input  logic                            ahb_hclk,
	input  logic                            ahb_hrstn,
	input  logic                            start,
	input  logic [eth_dma_pkg::DATA_W-1:0]  base_addr,
	input  logic [eth_dma_pkg::WCNT_W-1:0]  word_cnt,
	input  logic [eth_dma_pkg::CNT_W-1:0]   count,
	output logic                            ahb_hsel,
	output logic [1:0]                      ahb_htrans,
	output logic [2:0]                      ahb_hsize,
	output logic                            ahb_hwrite,
	output logic [2:0]                      ahb_hburst,
	output logic [3:0]                      ahb_hprot,
	output logic [eth_dma_pkg::DATA_W-1:0]  ahb_haddr,
	input  logic                            ahb_hready,
	input  logic [1:0]                      ahb_hresp,
	input  logic [eth_dma_pkg::DATA_W-1:0]  ahb_hrdata,
	output logic                            push,
	output logic [eth_dma_pkg::DATA_W-1:0]  push_data,
	output logic                            done,
	output logic                            hresp_err
);

	import eth_dma_pkg::*;

	// transfer on the bus in address phase / data phase
	logic               a_valid;
	logic               d_valid;
	logic [DATA_W-1:0]  addr_q;
	// words still to issue and still to complete
	logic [WCNT_W-1:0]  issue_left;
	logic [WCNT_W-1:0]  cmpl_left;
	logic [CNT_W:0]     pending;
	logic               issue;
	logic               data_err;

	//================================================
	// back-pressure
	//================================================
	// fifo fill plus transfers not yet pushed
	assign pending = {1'b0, count} + {{CNT_W{1'b0}}, a_valid} + {{CNT_W{1'b0}}, d_valid};
	assign issue = (pending < (CNT_W+1)'(FIFO_DEPTH)) && (issue_left != '0);

	assign data_err = d_valid && ahb_hresp == HRESP_ERROR;
	assign push = d_valid && ahb_hready && ahb_hresp == HRESP_OKAY;
	assign push_data = ahb_hrdata;

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			a_valid <= 1'b0;
			d_valid <= 1'b0;
			addr_q <= '0;
			issue_left <= '0;
			cmpl_left <= '0;
			done <= 1'b0;
			hresp_err <= 1'b0;
		end
		else
		begin
			done <= push && cmpl_left == WCNT_W'(1);
			// second cycle of the two-cycle error response
			hresp_err <= data_err && ahb_hready;
			if (start)
			begin
				// first address phase right after start
				a_valid <= word_cnt != '0;
				d_valid <= 1'b0;
				addr_q <= base_addr;
				issue_left <= (word_cnt != '0) ? word_cnt - WCNT_W'(1) : '0;
				cmpl_left <= word_cnt;
			end
			else if (data_err)
			begin
				// go idle, the rest of the buffer is dropped
				a_valid <= 1'b0;
				issue_left <= '0;
				cmpl_left <= '0;
				if (ahb_hready)
					d_valid <= 1'b0;
			end
			else if (ahb_hready)
			begin
				// pipeline advances only on hready
				d_valid <= a_valid;
				a_valid <= issue;
				if (issue)
				begin
					addr_q <= addr_q + DATA_W'(4);
					issue_left <= issue_left - WCNT_W'(1);
				end
				if (push)
					cmpl_left <= cmpl_left - WCNT_W'(1);
			end
		end
	end

	//================================================
	// bus outputs
	//================================================
	assign ahb_hsel = a_valid;
	assign ahb_htrans = a_valid ? HTRANS_NONSEQ : HTRANS_IDLE;
	assign ahb_haddr = addr_q;
	assign ahb_hwrite = 1'b0;
	assign ahb_hsize = HSIZE_WORD;
	assign ahb_hburst = HBURST_SINGLE;
	assign ahb_hprot = HPROT_DATA;

endmodule

`default_nettype wire

//--- hdl/eth_tx_fifo.sv
//================================================
// tx data buffer, first-word fall-through
// push into a full fifo and pop from an empty one are ignored
// flush wins over a push in the same cycle
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_tx_fifo
(
	input  logic                            ahb_hclk,
	input  logic                            ahb_hrstn,
	input  logic                            push,
	input  logic [eth_dma_pkg::DATA_W-1:0]  push_data,
	input  logic                            pop,
	input  logic                            flush,
	output logic [eth_dma_pkg::DATA_W-1:0]  pop_data,
	output logic                            empty,
	output logic [eth_dma_pkg::CNT_W-1:0]   count
);

	import eth_dma_pkg::*;

	logic [DATA_W-1:0]  mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic               full;
	logic               wr_en;
	logic               rd_en;

	assign full = count == CNT_W'(FIFO_DEPTH);
	assign empty = count == '0;
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;
	// head word visible without a pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// pointers wrap naturally
			if (wr_en)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (rd_en)
				rd_ptr <= rd_ptr + PTR_W'(1);
			if (wr_en && !rd_en)
				count <= count + CNT_W'(1);
			else if (rd_en && !wr_en)
				count <= count - CNT_W'(1);
		end
	end

	always_ff @(posedge ahb_hclk)
	begin
		if (wr_en && !flush)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- hdl/eth_tx_pe_port.sv
//================================================
// four-phase req/ack port to the mac tx engine
// one word per handshake, rdata held while ack is high
// last_taken pulses as ack falls on the final word
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_tx_pe_port
(
	input  logic                            ahb_hclk,
	input  logic                            ahb_hrstn,
	input  logic                            txdb_pe_req,
	input  logic [eth_dma_pkg::DATA_W-1:0]  pop_data,
	input  logic                            empty,
	input  logic [eth_dma_pkg::WCNT_W-1:0]  word_cnt,
	input  logic                            start,
	output logic                            pop,
	output logic                            txdb_pe_ack,
	output logic [eth_dma_pkg::DATA_W-1:0]  txdb_rdata,
	output logic                            data_ready,
	output logic                            last_taken
);

	import eth_dma_pkg::*;

	// words of this buffer not yet handed over
	logic [WCNT_W-1:0]  left;
	// word behind the current ack is the final one
	logic               last_q;
	logic               ack_fall;

	// new word only between handshakes
	assign pop = txdb_pe_req && !txdb_pe_ack && !empty && left != '0;
	assign ack_fall = txdb_pe_ack && !txdb_pe_req;

	always_ff @(posedge ahb_hclk or negedge ahb_hrstn)
	begin
		if (!ahb_hrstn)
		begin
			txdb_pe_ack <= 1'b0;
			left <= '0;
			last_q <= 1'b0;
			last_taken <= 1'b0;
			data_ready <= 1'b0;
		end
		else
		begin
			data_ready <= !empty;
			last_taken <= ack_fall && last_q;
			if (pop)
				txdb_pe_ack <= 1'b1;
			else if (ack_fall)
				txdb_pe_ack <= 1'b0;
			if (start)
			begin
				left <= word_cnt;
				last_q <= 1'b0;
			end
			else if (pop)
			begin
				left <= left - WCNT_W'(1);
				last_q <= left == WCNT_W'(1);
			end
		end
	end

	// word register for the engine
	always_ff @(posedge ahb_hclk)
	begin
		if (pop)
			txdb_rdata <= pop_data;
	end

endmodule

`default_nettype wire

//--- hdl/eth_mac_tx_dma.sv
//================================================
// ethernet mac tx dma, one descriptor per enable
// r_tdes0 is the buffer address, r_tdes3[11:0] the byte length
// length must be nonzero and at most 4092 bytes
// buffer address must be word aligned
// enable_end and process_finish are the same event
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx_dma
(
	input  logic                            ahb_hclk,
	input  logic                            ahb_hrstn,

	// register side
	input  logic                            txdb_enable,
	input  logic [eth_dma_pkg::DATA_W-1:0]  r_tdes0,
	input  logic [eth_dma_pkg::DATA_W-1:0]  r_tdes3,

	// ahb-lite master
	output logic                            ahb_hsel,
	output logic [1:0]                      ahb_htrans,
	output logic [2:0]                      ahb_hsize,
	output logic                            ahb_hwrite,
	output logic [2:0]                      ahb_hburst,
	output logic [3:0]                      ahb_hprot,
	output logic [eth_dma_pkg::DATA_W-1:0]  ahb_haddr,
	input  logic                            ahb_hready,
	input  logic [1:0]                      ahb_hresp,
	input  logic [eth_dma_pkg::DATA_W-1:0]  ahb_hrdata,

	// protocol engine side
	input  logic                            txdb_pe_req,
	output logic                            txdb_pe_ack,
	output logic [eth_dma_pkg::DATA_W-1:0]  txdb_rdata,
	output logic                            txdb_data_ready,
	output logic                            txdb_process_doing,
	output logic                            txdb_enable_end,

	// interrupt status
	output logic                            int_status_dma_hresp_error,
	output logic                            int_status_dma_process_finish
);

	import eth_dma_pkg::*;

	//================================================
	// block to block wires
	//================================================
	// control fsm to reader
	logic               start;
	logic [DATA_W-1:0]  base_addr;
	logic [WCNT_W-1:0]  word_cnt;
	logic               done;
	logic               hresp_err;
	// reader to fifo
	logic               push;
	logic [DATA_W-1:0]  push_data;
	logic [CNT_W-1:0]   count;
	// fifo to pe port
	logic               pop;
	logic [DATA_W-1:0]  pop_data;
	logic               empty;
	logic               fifo_flush;
	logic               last_taken;

	eth_datalink_ctrl eth_datalink_ctrl_i
	(
		.ahb_hclk      (ahb_hclk),
		.ahb_hrstn     (ahb_hrstn),
		.txdb_enable   (txdb_enable),
		.r_tdes0       (r_tdes0),
		.r_tdes3       (r_tdes3),
		.done          (done),
		.hresp_err     (hresp_err),
		.last_taken    (last_taken),
		.start         (start),
		.base_addr     (base_addr),
		.word_cnt      (word_cnt),
		.fifo_flush    (fifo_flush),
		.process_doing (txdb_process_doing)
	);

	eth_dma_ahb_reader eth_dma_ahb_reader_i
	(
		.ahb_hclk   (ahb_hclk),
		.ahb_hrstn  (ahb_hrstn),
		.start      (start),
		.base_addr  (base_addr),
		.word_cnt   (word_cnt),
		.count      (count),
		.ahb_hsel   (ahb_hsel),
		.ahb_htrans (ahb_htrans),
		.ahb_hsize  (ahb_hsize),
		.ahb_hwrite (ahb_hwrite),
		.ahb_hburst (ahb_hburst),
		.ahb_hprot  (ahb_hprot),
		.ahb_haddr  (ahb_haddr),
		.ahb_hready (ahb_hready),
		.ahb_hresp  (ahb_hresp),
		.ahb_hrdata (ahb_hrdata),
		.push       (push),
		.push_data  (push_data),
		.done       (done),
		.hresp_err  (hresp_err)
	);

	eth_tx_fifo eth_tx_fifo_i
	(
		.ahb_hclk  (ahb_hclk),
		.ahb_hrstn (ahb_hrstn),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.flush     (fifo_flush),
		.pop_data  (pop_data),
		.empty     (empty),
		.count     (count)
	);

	eth_tx_pe_port eth_tx_pe_port_i
	(
		.ahb_hclk    (ahb_hclk),
		.ahb_hrstn   (ahb_hrstn),
		.txdb_pe_req (txdb_pe_req),
		.pop_data    (pop_data),
		.empty       (empty),
		.word_cnt    (word_cnt),
		.start       (start),
		.pop         (pop),
		.txdb_pe_ack (txdb_pe_ack),
		.txdb_rdata  (txdb_rdata),
		.data_ready  (txdb_data_ready),
		.last_taken  (last_taken)
	);

	// single descriptor, so the end of the ring is the end of the frame
	assign txdb_enable_end = last_taken;
	assign int_status_dma_process_finish = last_taken;
	assign int_status_dma_hresp_error = hresp_err;

endmodule

`default_nettype wire

//--- dv/eth_mac_tx_dma_props.sv
//================================================
// bound checks for the tx dma top level
// ahb address hold rule and the pe four-phase rules
// reset values checked during and just after reset
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx_dma_props
(
	input wire logic        ahb_hclk,
	input wire logic        ahb_hrstn,
	input wire logic        ahb_hsel,
	input wire logic [1:0]  ahb_htrans,
	input wire logic [31:0] ahb_haddr,
	input wire logic        ahb_hready,
	input wire logic [1:0]  ahb_hresp,
	input wire logic        txdb_pe_req,
	input wire logic        txdb_pe_ack,
	input wire logic [31:0] txdb_rdata,
	input wire logic        txdb_data_ready,
	input wire logic        txdb_process_doing,
	input wire logic        int_status_dma_hresp_error,
	input wire logic        int_status_dma_process_finish
);

	import eth_dma_pkg::*;

	logic quiet;

	// everything that must be low out of reset
	assign quiet = ahb_htrans == HTRANS_IDLE && !ahb_hsel && !txdb_pe_ack
		&& !txdb_process_doing && !txdb_data_ready
		&& !int_status_dma_hresp_error && !int_status_dma_process_finish;

	//================================================
	// reset
	//================================================
	a_reset_low: assert property (@(posedge ahb_hclk) !ahb_hrstn |-> quiet)
		else $error("outputs not low during reset");
	a_reset_exit: assert property (@(posedge ahb_hclk) $rose(ahb_hrstn) |-> quiet)
		else $error("outputs not low right after reset");

	//================================================
	// ahb, a waited address phase holds
	//================================================
	// an error response may cancel the next transfer, so only okay waits count
	a_addr_hold: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		(!ahb_hready && ahb_htrans == HTRANS_NONSEQ && ahb_hresp == HRESP_OKAY)
		|=> ($stable(ahb_haddr) && ahb_htrans == HTRANS_NONSEQ))
		else $error("haddr or htrans changed during a wait state");

	//================================================
	// four-phase handshake
	//================================================
	a_ack_rise: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		$rose(txdb_pe_ack) |-> $past(txdb_pe_req))
		else $error("ack rose without req");
	a_rdata_hold: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		($past(txdb_pe_ack) && txdb_pe_ack) |-> $stable(txdb_rdata))
		else $error("rdata changed while ack was high");
	a_ack_fall: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		$fell(txdb_pe_ack) |-> !$past(txdb_pe_req))
		else $error("ack fell while req was still high");
	// rule on the engine side, guards the pe model
	a_req_rise: assert property (@(posedge ahb_hclk) disable iff (!ahb_hrstn)
		$rose(txdb_pe_req) |-> !$past(txdb_pe_ack))
		else $error("req rose before ack fell");

endmodule

bind eth_mac_tx_dma eth_mac_tx_dma_props eth_mac_tx_dma_props_i
(
	.ahb_hclk                      (ahb_hclk),
	.ahb_hrstn                     (ahb_hrstn),
	.ahb_hsel                      (ahb_hsel),
	.ahb_htrans                    (ahb_htrans),
	.ahb_haddr                     (ahb_haddr),
	.ahb_hready                    (ahb_hready),
	.ahb_hresp                     (ahb_hresp),
	.txdb_pe_req                   (txdb_pe_req),
	.txdb_pe_ack                   (txdb_pe_ack),
	.txdb_rdata                    (txdb_rdata),
	.txdb_data_ready               (txdb_data_ready),
	.txdb_process_doing            (txdb_process_doing),
	.int_status_dma_hresp_error    (int_status_dma_hresp_error),
	.int_status_dma_process_finish (int_status_dma_process_finish)
);

`default_nettype wire

//--- dv/eth_mac_tx_dma_tb.sv
//================================================
// testbench for the tx dma path, one descriptor per run
// ahb slave returns address xor 5a5a0000, random waits
// pe model takes words with random gaps
// error run keeps the pe idle so words stay in the fifo
//================================================

`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx_dma_tb;

	import eth_dma_pkg::*;

	localparam int TIMEOUT = 4000;

	logic ahb_hclk;
	logic ahb_hrstn;
	logic txdb_enable;
	logic [31:0] r_tdes0;
	logic [31:0] r_tdes3;
	logic ahb_hsel;
	logic [1:0] ahb_htrans;
	logic [2:0] ahb_hsize;
	logic ahb_hwrite;
	logic [2:0] ahb_hburst;
	logic [3:0] ahb_hprot;
	logic [31:0] ahb_haddr;
	logic ahb_hready;
	logic [1:0] ahb_hresp;
	logic [31:0] ahb_hrdata;
	logic txdb_pe_req;
	logic txdb_pe_ack;
	logic [31:0] txdb_rdata;
	logic txdb_data_ready;
	logic txdb_process_doing;
	logic txdb_enable_end;
	logic int_status_dma_hresp_error;
	logic int_status_dma_process_finish;

	int seed;
	int errors;
	int checks;
	// run setup
	logic [31:0] exp_base;
	logic [31:0] err_addr;
	logic pe_on;
	logic slow;
	// event counts of the current run
	int delivered;
	int reads_ok;
	int finish_cnt;
	int end_cnt;
	int herr_cnt;
	// slave data phase
	logic d_ph;
	logic [31:0] d_addr;
	int wait_n;
	int err_step;
	logic [1:0] prev_htrans;
	logic [31:0] prev_haddr;
	logic prev_hready;
	// pe model state and gap
	int pe_st;
	int gap;

	eth_mac_tx_dma eth_mac_tx_dma_i
	(
		.ahb_hclk                      (ahb_hclk),
		.ahb_hrstn                     (ahb_hrstn),
		.txdb_enable                   (txdb_enable),
		.r_tdes0                       (r_tdes0),
		.r_tdes3                       (r_tdes3),
		.ahb_hsel                      (ahb_hsel),
		.ahb_htrans                    (ahb_htrans),
		.ahb_hsize                     (ahb_hsize),
		.ahb_hwrite                    (ahb_hwrite),
		.ahb_hburst                    (ahb_hburst),
		.ahb_hprot                     (ahb_hprot),
		.ahb_haddr                     (ahb_haddr),
		.ahb_hready                    (ahb_hready),
		.ahb_hresp                     (ahb_hresp),
		.ahb_hrdata                    (ahb_hrdata),
		.txdb_pe_req                   (txdb_pe_req),
		.txdb_pe_ack                   (txdb_pe_ack),
		.txdb_rdata                    (txdb_rdata),
		.txdb_data_ready               (txdb_data_ready),
		.txdb_process_doing            (txdb_process_doing),
		.txdb_enable_end               (txdb_enable_end),
		.int_status_dma_hresp_error    (int_status_dma_hresp_error),
		.int_status_dma_process_finish (int_status_dma_process_finish)
	);

	initial
	begin
		ahb_hclk = 1'b0;
		forever #50 ahb_hclk = ~ahb_hclk;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (exp == got)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// one cycle, landing just after the models have driven
	task automatic step();
		@(posedge ahb_hclk);
		#6;
	endtask

	//================================================
	// ahb slave, pe model and event counts
	//================================================
	always @(posedge ahb_hclk)
	begin
		#5;
		if (ahb_hrstn)
		begin
			if (int_status_dma_process_finish)
			begin
				finish_cnt++;
				check_value("txdb_pe_ack at finish", 32'd0, {31'd0, txdb_pe_ack});
			end
			if (txdb_enable_end)
				end_cnt++;
			if (int_status_dma_hresp_error)
				herr_cnt++;
			// single privileged word reads, slave selected
			if (ahb_htrans == HTRANS_NONSEQ)
			begin
				check_value("ahb_hsel", 32'd1, {31'd0, ahb_hsel});
				check_value("ahb_hwrite", 32'd0, {31'd0, ahb_hwrite});
				check_value("ahb_hsize", 32'd2, {29'd0, ahb_hsize});
				check_value("ahb_hburst", 32'd0, {29'd0, ahb_hburst});
				check_value("ahb_hprot", 32'd3, {28'd0, ahb_hprot});
			end
			// a data phase ends on an edge with hready high
			if (prev_hready)
			begin
				if (d_ph && err_step == 0)
					reads_ok++;
				d_ph = prev_htrans == HTRANS_NONSEQ;
				d_addr = prev_haddr;
				wait_n = slow ? ($random(seed) & 3) : ($random(seed) & 1);
				err_step = 0;
			end
			ahb_hready = 1'b1;
			ahb_hresp = HRESP_OKAY;
			ahb_hrdata = 32'h0;
			if (d_ph && d_addr == err_addr)
			begin
				// two-cycle error response
				ahb_hresp = HRESP_ERROR;
				ahb_hready = err_step != 0;
				err_step++;
			end
			else if (d_ph && wait_n > 0)
			begin
				ahb_hready = 1'b0;
				wait_n--;
			end
			else if (d_ph)
				ahb_hrdata = d_addr ^ 32'h5A5A_0000;
			prev_htrans = ahb_htrans;
			prev_haddr = ahb_haddr;
			prev_hready = ahb_hready;
			checks++;
			assert (reads_ok - delivered <= FIFO_DEPTH)
			else
			begin
				errors++;
				$display("more words read than the fifo can hold ahead of the pe");
			end
			// pe: gap, req until ack, then wait for ack low
			case (pe_st)
				0:
					if (pe_on && gap == 0)
					begin
						txdb_pe_req = 1'b1;
						pe_st = 1;
					end
					else if (gap > 0)
						gap--;
				1:
					if (txdb_pe_ack)
					begin
						check_value("txdb_rdata", (exp_base + (delivered << 2)) ^ 32'h5A5A_0000,
							txdb_rdata);
						check_value("txdb_data_ready", 32'd1, {31'd0, txdb_data_ready});
						delivered++;
						txdb_pe_req = 1'b0;
						pe_st = 2;
					end
					else if (!pe_on)
					begin
						txdb_pe_req = 1'b0;
						pe_st = 0;
					end
				default:
					if (!txdb_pe_ack)
					begin
						gap = slow ? ($random(seed) & 7) : ($random(seed) & 1);
						pe_st = 0;
					end
			endcase
		end
	end

	task automatic start_buffer(input logic [31:0] base, input logic [11:0] len);
		step();
		exp_base = base;
		delivered = 0;
		reads_ok = 0;
		finish_cnt = 0;
		end_cnt = 0;
		herr_cnt = 0;
		r_tdes0 = base;
		r_tdes3 = {20'h0, len};
		txdb_enable = 1'b1;
		step();
		txdb_enable = 1'b0;
	endtask

	// wait for the finish or the error interrupt
	task automatic wait_irq(input string what);
		int i;
		i = 0;
		while (finish_cnt == 0 && herr_cnt == 0 && i < TIMEOUT)
		begin
			step();
			i++;
		end
		if (finish_cnt == 0 && herr_cnt == 0)
		begin
			errors++;
			$display("timeout waiting for the %s interrupt", what);
		end
	endtask

	// wait for the fsm to leave tx-data, then a few quiet cycles
	task automatic wait_idle();
		int i;
		i = 0;
		step();
		while (txdb_process_doing && i < TIMEOUT)
		begin
			step();
			i++;
		end
		if (txdb_process_doing)
		begin
			errors++;
			$display("timeout waiting for the dma process to end");
		end
		repeat (8) step();
		// every word taken or flushed
		check_value("txdb_data_ready", 32'd0, {31'd0, txdb_data_ready});
	endtask

	task automatic run_buffer(input logic [31:0] base, input logic [11:0] len, input int words);
		start_buffer(base, len);
		wait_irq("finish");
		wait_idle();
		check_value("delivered words", words, delivered);
		check_value("int_status_dma_process_finish pulses", 1, finish_cnt);
		check_value("txdb_enable_end pulses", 1, end_cnt);
	endtask

	initial
	begin
		seed = 53;
		errors = 0;
		checks = 0;
		ahb_hrstn = 1'b0;
		txdb_enable = 1'b0;
		r_tdes0 = 32'h0;
		r_tdes3 = 32'h0;
		ahb_hready = 1'b1;
		ahb_hresp = HRESP_OKAY;
		ahb_hrdata = 32'h0;
		txdb_pe_req = 1'b0;
		exp_base = 32'h0;
		err_addr = 32'hFFFF_FFFF;
		pe_on = 1'b1;
		slow = 1'b0;
		d_ph = 1'b0;
		prev_hready = 1'b1;
		prev_htrans = HTRANS_IDLE;
		pe_st = 0;
		gap = 0;
		repeat (16) @(posedge ahb_hclk);
		#5;
		ahb_hrstn = 1'b1;
		// lengths round up to 1, 4 and 10 words
		run_buffer(32'h0000_1000, 12'd4, 1);
		run_buffer(32'h0000_2000, 12'd13, 4);
		run_buffer(32'h0000_3000, 12'd40, 10);
		// slow pe fills the fifo and stalls the reads
		slow = 1'b1;
		run_buffer(32'h0000_4000, 12'd128, 32);
		// error on the fourth word with the pe idle
		pe_on = 1'b0;
		err_addr = 32'h0000_500C;
		start_buffer(32'h0000_5000, 12'd40);
		wait_irq("error");
		wait_idle();
		check_value("int_status_dma_hresp_error pulses", 1, herr_cnt);
		check_value("int_status_dma_process_finish pulses", 0, finish_cnt);
		check_value("txdb_process_doing", 0, {31'd0, txdb_process_doing});
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// whole-run limit
	initial
	begin
		#(100 * 200000);
		$display("simulation ran past its time limit");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/eth_dma_pkg.sv
hdl/eth_datalink_ctrl.sv
hdl/eth_dma_ahb_reader.sv
hdl/eth_tx_fifo.sv
hdl/eth_tx_pe_port.sv
hdl/eth_mac_tx_dma.sv
dv/eth_mac_tx_dma_props.sv
dv/eth_mac_tx_dma_tb.sv

//--- run.sh
#!/bin/sh
# build and run the tx dma testbench with verilator, from the project root
verilator --binary --timing --assert -f list.f --top-module eth_mac_tx_dma_tb \
	-o eth_mac_tx_dma_sim > build.log 2>&1 \
	&& ./obj_dir/eth_mac_tx_dma_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
